//--- source/pc_hard_pkg.sv
/*
  Shared sizes, redirect codes, event structs and register map of the
  PC-hardening monitor.
  Events have no back-pressure; an event counts only while its valid is high.
  Struct fields are listed MSB first, so seq and pc_hardening sit at bit 0
  of the status and control registers.
  The register port is AXI4-Lite with 4-bit byte addresses and 32-bit data.
*/
package pc_hard_pkg;

  // Datapath and counter sizes
  localparam int unsigned pc_w  = 32;
  localparam int unsigned cnt_w = 16;

  // Register port sizes
  localparam int unsigned axil_aw = 4;
  localparam int unsigned axil_dw = 32;

  // Sequential fetch increments
  localparam logic [pc_w-1:0] incr_cmpr = pc_w'(2);
  localparam logic [pc_w-1:0] incr_full = pc_w'(4);

  // Redirect kinds, same codes as the core's PC mux
  typedef enum logic [3:0] {
    pc_mret   = 4'b0001,
    pc_jump   = 4'b0100,
    pc_branch = 4'b0101
  } pc_mux_e;

  // One IF/ID hand-over
  typedef struct packed {
    logic            valid;
    logic [pc_w-1:0] pc_if;
    logic [pc_w-1:0] pc_id;
    logic            is_cmpr;
    logic            last_op;
    logic            ptr;
    logic            dummy;
    logic            pc_set;
  } fetch_ev_t;

  // One redirect with its duplicated target and decision
  typedef struct packed {
    logic            valid;
    pc_mux_e         kind;
    logic [pc_w-1:0] tgt_a;
    logic [pc_w-1:0] tgt_b;
    logic            cmp_a;
    logic            cmp_b;
  } redir_ev_t;

  // Fault pulses, also the layout of the status register
  typedef struct packed {
    logic dec;
    logic tgt;
    logic seq;
  } fault_t;

  // Control register layout
  typedef struct packed {
    logic dataindtiming;
    logic pc_hardening;
  } hard_cfg_t;

  // Master side of AXI4-Lite
  typedef struct packed {
    logic               awvalid;
    logic [axil_aw-1:0] awaddr;
    logic               wvalid;
    logic [axil_dw-1:0] wdata;
    logic [3:0]         wstrb;
    logic               bready;
    logic               arvalid;
    logic [axil_aw-1:0] araddr;
    logic               rready;
  } axil_req_t;

  // Slave side of AXI4-Lite
  typedef struct packed {
    logic               awready;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               arready;
    logic               rvalid;
    logic [axil_dw-1:0] rdata;
    logic [1:0]         rresp;
  } axil_rsp_t;

  // Register byte addresses
  localparam logic [axil_aw-1:0] reg_ctrl   = 4'h0;
  localparam logic [axil_aw-1:0] reg_status = 4'h4;
  localparam logic [axil_aw-1:0] reg_count  = 4'h8;

  // Response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- source/pc_seq_check.sv
/*
  Sequential PC check on the IF/ID hand-over.
  Only last-op, non-pointer events are checked.
  Dummy instructions, redirects and the all-zero post-reset state are
  excused, as is the event right after a redirect.
  fault_o is a registered pulse, one cycle after the event edge.
*/
module pc_seq_check (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  pc_hard_pkg::hard_cfg_t cfg_i,
  input  pc_hard_pkg::fetch_ev_t fetch_i,
  output logic                   fault_o
);

  logic [pc_hard_pkg::pc_w-1:0] pc_exp;
  logic                         checked;
  logic                         mismatch;
  logic                         excused;
  logic                         reset_pc;
  logic                         fault_d;
  logic                         prev_set_q;

  // Expected IF PC from the decode PC and the instruction size
  assign pc_exp = fetch_i.pc_id +
                  (fetch_i.is_cmpr ? pc_hard_pkg::incr_cmpr : pc_hard_pkg::incr_full);

  // Multi-op instructions are checked on their last op only
  // Table pointer fetches are not sequential by nature
  assign checked = fetch_i.valid && fetch_i.last_op && !fetch_i.ptr;

  assign mismatch = (fetch_i.pc_if != pc_exp);

  // Both PCs still zero right after reset
  assign reset_pc = (fetch_i.pc_if == '0) && (fetch_i.pc_id == '0);

  // Allowed non-sequential cases
  assign excused = fetch_i.dummy || fetch_i.pc_set || prev_set_q || reset_pc;

  // Faults are dropped while hardening is off
  assign fault_d = cfg_i.pc_hardening && checked && mismatch && !excused;

  // Remember pc_set of the last valid event
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prev_set_q <= 1'b0;
    end else if (fetch_i.valid) begin
      prev_set_q <= fetch_i.pc_set;
    end
  end

  // Registered fault pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fault_o <= 1'b0;
    end else begin
      fault_o <= fault_d;
    end
  end

  // Hardening off in one cycle leaves the next cycle quiet
  a_no_fault_when_off: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !cfg_i.pc_hardening |=> !fault_o
  ) else $error("seq fault raised while pc_hardening was off");

endmodule

//--- source/pc_target_check.sv
/*
  Redirect check for branch, jump and mret.
  The target is computed twice and both copies must agree for every kind.
  Branch decisions are compared too, except with dataindtiming set, where
  branches are always taken and the decision is not used.
  Both fault outputs are registered pulses, one cycle after the event edge.
  Redirect kinds outside the three defined codes are not expected.
*/
module pc_target_check (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  pc_hard_pkg::hard_cfg_t cfg_i,
  input  pc_hard_pkg::redir_ev_t redir_i,
  output logic                   tgt_fault_o,
  output logic                   dec_fault_o
);

  logic is_branch;
  logic tgt_mis;
  logic dec_mis;
  logic tgt_fault_d;
  logic dec_fault_d;

  assign is_branch = (redir_i.kind == pc_hard_pkg::pc_branch);

  // Target copies must match for every redirect kind
  assign tgt_mis = redir_i.tgt_a != redir_i.tgt_b;

  // Decision copies only matter for real branches
  assign dec_mis = is_branch && !cfg_i.dataindtiming && (redir_i.cmp_a != redir_i.cmp_b);

  // Gate with valid and the hardening enable
  assign tgt_fault_d = cfg_i.pc_hardening && redir_i.valid && tgt_mis;
  assign dec_fault_d = cfg_i.pc_hardening && redir_i.valid && dec_mis;

  // Registered fault pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tgt_fault_o <= 1'b0;
      dec_fault_o <= 1'b0;
    end else begin
      tgt_fault_o <= tgt_fault_d;
      dec_fault_o <= dec_fault_d;
    end
  end

  // A decision fault is always the echo of a valid branch
  a_dec_after_branch: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dec_fault_o |-> $past(redir_i.valid && redir_i.kind == pc_hard_pkg::pc_branch)
  ) else $error("decision fault without a preceding branch event");

  // Only the three redirect codes come from the PC mux
  a_kind_legal: assert property (
    @(posedge clk_i) disable iff (reset_i)
    redir_i.valid |-> redir_i.kind inside {pc_hard_pkg::pc_branch,
                                           pc_hard_pkg::pc_jump,
                                           pc_hard_pkg::pc_mret}
  ) else $error("redirect with undefined kind 0x%h", redir_i.kind);

endmodule

//--- source/pc_alert_ctrl.sv
/*
  Alert and fault bookkeeping.
  alert_major_o is a one-cycle pulse, one cycle after any fault pulse.
  Status bits are sticky; a clear and a new fault on the same bit in the
  same cycle leave the bit set.
  The fault counter counts cycles with any fault and stops at all ones.
*/
module pc_alert_ctrl (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  pc_hard_pkg::fault_t           fault_i,
  input  pc_hard_pkg::fault_t           clr_i,
  output logic                          alert_major_o,
  output pc_hard_pkg::fault_t           status_o,
  output logic [pc_hard_pkg::cnt_w-1:0] count_o
);

  pc_hard_pkg::fault_t           status_q;
  pc_hard_pkg::fault_t           status_d;
  logic [pc_hard_pkg::cnt_w-1:0] count_q;
  logic                          any_fault;
  logic                          count_full;

  assign any_fault = |fault_i;

  assign count_full = &count_q;

  // New faults win over a clear in the same cycle
  assign status_d = pc_hard_pkg::fault_t'((status_q & ~clr_i) | fault_i);

  // Major alert, one pulse per faulting cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alert_major_o <= 1'b0;
    end else begin
      alert_major_o <= any_fault;
    end
  end

  // Sticky status
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  // Saturating fault counter
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (any_fault && !count_full) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign status_o = status_q;
  assign count_o  = count_q;

  // Once saturated the count must stay there
  a_count_no_wrap: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (&count_q) |=> (count_q != '0)
  ) else $error("fault counter wrapped from all ones");

endmodule

//--- source/pc_hard_csr.sv
/*
  AXI4-Lite register slave: control at 0x0, status at 0x4, count at 0x8.
  One transaction per direction; a write needs AW and W in the same cycle.
  Status is write-1-to-clear; count is read only and ignores writes.
  Write strobes only matter for byte 0 of control and status.
  Unmapped addresses answer SLVERR, reads with zero data.
  After reset pc_hardening is 1 and dataindtiming is 0.
*/
module pc_hard_csr (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  pc_hard_pkg::axil_req_t        axil_i,
  output pc_hard_pkg::axil_rsp_t        axil_o,
  input  pc_hard_pkg::fault_t           status_i,
  input  logic [pc_hard_pkg::cnt_w-1:0] count_i,
  output pc_hard_pkg::hard_cfg_t        cfg_o,
  output pc_hard_pkg::fault_t           clr_o
);

  localparam int unsigned cfg_bits = $bits(pc_hard_pkg::hard_cfg_t);
  localparam int unsigned flt_bits = $bits(pc_hard_pkg::fault_t);

  pc_hard_pkg::hard_cfg_t          ctrl_q;
  logic                            wr_acc;
  logic                            rd_acc;
  logic                            wr_mapped;
  logic                            bvalid_q;
  logic                            rvalid_q;
  logic [1:0]                      bresp_q;
  logic [1:0]                      rresp_q;
  logic [1:0]                      rd_resp;
  logic [pc_hard_pkg::axil_dw-1:0] rd_data;
  logic [pc_hard_pkg::axil_dw-1:0] rdata_q;

  // Accept only with no response pending on that channel
  assign wr_acc = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
  assign rd_acc = axil_i.arvalid && !rvalid_q;

  assign wr_mapped = (axil_i.awaddr == pc_hard_pkg::reg_ctrl) ||
                     (axil_i.awaddr == pc_hard_pkg::reg_status) ||
                     (axil_i.awaddr == pc_hard_pkg::reg_count);

  // W1C pulse, lands in the status register at the acceptance edge
  always_comb begin
    clr_o = '0;
    if (wr_acc && axil_i.awaddr == pc_hard_pkg::reg_status && axil_i.wstrb[0]) begin
      clr_o = pc_hard_pkg::fault_t'(axil_i.wdata[flt_bits-1:0]);
    end
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    rd_resp = pc_hard_pkg::resp_okay;
    case (axil_i.araddr)
      pc_hard_pkg::reg_ctrl:   rd_data[cfg_bits-1:0] = ctrl_q;
      pc_hard_pkg::reg_status: rd_data[flt_bits-1:0] = status_i;
      pc_hard_pkg::reg_count:  rd_data[pc_hard_pkg::cnt_w-1:0] = count_i;
      default:                 rd_resp = pc_hard_pkg::resp_slverr;
    endcase
  end

  // Control register and write response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q.pc_hardening  <= 1'b1;
      ctrl_q.dataindtiming <= 1'b0;
      bvalid_q             <= 1'b0;
    end else begin
      if (wr_acc) begin
        bvalid_q <= 1'b1;
        if (axil_i.awaddr == pc_hard_pkg::reg_ctrl && axil_i.wstrb[0]) begin
          ctrl_q <= pc_hard_pkg::hard_cfg_t'(axil_i.wdata[cfg_bits-1:0]);
        end
      end else if (axil_i.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      bresp_q <= wr_mapped ? pc_hard_pkg::resp_okay : pc_hard_pkg::resp_slverr;
    end
  end

  // Read response, data held until rready
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_acc) begin
      rvalid_q <= 1'b1;
    end else if (axil_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  assign cfg_o = ctrl_q;

  // AW and W ready pulse together
  assign axil_o.awready = wr_acc;
  assign axil_o.wready  = wr_acc;
  assign axil_o.bvalid  = bvalid_q;
  assign axil_o.bresp   = bresp_q;
  assign axil_o.arready = rd_acc;
  assign axil_o.rvalid  = rvalid_q;
  assign axil_o.rdata   = rdata_q;
  assign axil_o.rresp   = rresp_q;

  // Responses stay up until the master takes them
  a_bvalid_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    bvalid_q && !axil_i.bready |=> bvalid_q && $stable(bresp_q)
  ) else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rvalid_q && !axil_i.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q)
  ) else $error("rvalid or rdata changed before rready");

endmodule

//--- source/pc_hard_top.sv
/*
  PC-hardening monitor top.
  Event to alert_major_o is exactly 2 cycles; status and count follow in
  the same cycle as the alert.
  Events are sampled every cycle without back-pressure.
*/
module pc_hard_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  pc_hard_pkg::fetch_ev_t fetch_i,
  input  pc_hard_pkg::redir_ev_t redir_i,
  input  pc_hard_pkg::axil_req_t axil_i,
  output pc_hard_pkg::axil_rsp_t axil_o,
  output logic                   alert_major_o
);

  pc_hard_pkg::hard_cfg_t        cfg;
  pc_hard_pkg::fault_t           faults;
  pc_hard_pkg::fault_t           clr;
  pc_hard_pkg::fault_t           status;
  logic [pc_hard_pkg::cnt_w-1:0] count;
  logic                          seq_fault;
  logic                          tgt_fault;
  logic                          dec_fault;

  // Sequential PC check
  pc_seq_check i_seq (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cfg_i   (cfg),
    .fetch_i (fetch_i),
    .fault_o (seq_fault)
  );

  // Redirect target and decision check
  pc_target_check i_tgt (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_i       (cfg),
    .redir_i     (redir_i),
    .tgt_fault_o (tgt_fault),
    .dec_fault_o (dec_fault)
  );

  // Gather the pulses in status bit order
  assign faults.seq = seq_fault;
  assign faults.tgt = tgt_fault;
  assign faults.dec = dec_fault;

  pc_alert_ctrl i_alert (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fault_i       (faults),
    .clr_i         (clr),
    .alert_major_o (alert_major_o),
    .status_o      (status),
    .count_o       (count)
  );

  pc_hard_csr i_csr (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .axil_i   (axil_i),
    .axil_o   (axil_o),
    .status_i (status),
    .count_i  (count),
    .cfg_o    (cfg),
    .clr_o    (clr)
  );

endmodule

//--- tb/pc_hard_tb.sv
/*
  Testbench for the PC-hardening monitor.
  Random fetch and redirect events and AXI4-Lite accesses from a fixed seed.
  Alert, status and count are checked every cycle against a reference model.
  Event streams stay idle while a register access is in progress.
  The saturation test alone runs for more than 2**cnt_w cycles.
*/
module pc_hard_tb;

  localparam int unsigned n_seq   = 400;
  localparam int unsigned n_flt   = 100;
  localparam int unsigned n_redir = 150;
  localparam int unsigned n_off   = 50;
  // Back-to-back faults, enough to run the counter into its limit
  localparam int unsigned sat_run = (1 << pc_hard_pkg::cnt_w) + 8;
  // Event cycles plus a margin for register accesses and flushes
  localparam int unsigned total_cycles = n_seq + n_flt + 2 * n_redir + 2 * n_off + sat_run + 1000;
  localparam int unsigned cycle_limit  = 4 * total_cycles + 200;

  logic                   clk_i = 1'b0;
  logic                   reset_i;
  pc_hard_pkg::fetch_ev_t fetch_i;
  pc_hard_pkg::redir_ev_t redir_i;
  pc_hard_pkg::axil_req_t axil_i;
  pc_hard_pkg::axil_rsp_t axil_o;
  logic                   alert_major_o;

  // Reference model state
  pc_hard_pkg::hard_cfg_t        m_cfg;
  pc_hard_pkg::hard_cfg_t        m_cfg_nxt;
  pc_hard_pkg::fault_t           m_status;
  pc_hard_pkg::fault_t           m_clr;
  pc_hard_pkg::fault_t           cur_fault;
  pc_hard_pkg::fault_t           alert_q[$];
  pc_hard_pkg::fault_t           saved_status;
  logic [pc_hard_pkg::cnt_w-1:0] m_count;
  logic [pc_hard_pkg::cnt_w-1:0] saved_count;
  logic                          m_prev_set;
  logic [31:0]                   seed;
  int unsigned                   cycle_cnt = 0;

  pc_hard_top i_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_i       (fetch_i),
    .redir_i       (redir_i),
    .axil_i        (axil_i),
    .axil_o        (axil_o),
    .alert_major_o (alert_major_o)
  );

  always #5 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      stop_on_error($sformatf("Timeout, run exceeded %0d cycles", cycle_limit));
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  task automatic check_alert(input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: alert_major_o got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_status(input pc_hard_pkg::fault_t got, input pc_hard_pkg::fault_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: status got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_count(input logic [pc_hard_pkg::cnt_w-1:0] got,
                             input logic [pc_hard_pkg::cnt_w-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: count got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR: rdata got 0x%h expected 0x%h", got, exp));
    end
  endtask

  // One clock; model follows the DUT edge, then outputs are compared
  task automatic step();
    pc_hard_pkg::fault_t f;
    @(posedge clk_i);
    #1;
    fetch_i.valid = 1'b0;
    redir_i.valid = 1'b0;
    // Fault of the event two edges back reaches alert, status and count now
    alert_q.push_back(cur_fault);
    cur_fault = '0;
    f = alert_q.pop_front();
    m_status = pc_hard_pkg::fault_t'((m_status & ~m_clr) | f);
    m_clr = '0;
    if ((|f) && m_count != {pc_hard_pkg::cnt_w{1'b1}}) begin
      m_count = m_count + 1'b1;
    end
    m_cfg = m_cfg_nxt;
    check_alert(alert_major_o, |f);
    check_status(i_dut.status, m_status);
    check_count(i_dut.count, m_count);
  endtask

  task automatic flush();
    repeat (3) step();
  endtask

  // Fetch event; bad forces a mismatch with no exception flags
  task automatic send_fetch(input logic bad);
    pc_hard_pkg::fetch_ev_t ev;
    logic [31:0]            r;
    logic [31:0]            nxt;
    logic                   excused;
    r = next_rand();
    ev.valid   = 1'b1;
    ev.pc_id   = next_rand() & ~32'h1;
    ev.is_cmpr = r[0];
    ev.last_op = bad || (r[3:1] != 3'd0);
    ev.ptr     = !bad && (r[6:4] == 3'd0);
    ev.dummy   = !bad && (r[9:7] == 3'd0);
    ev.pc_set  = !bad && (r[12:10] == 3'd0);
    nxt = ev.pc_id + (ev.is_cmpr ? 32'd2 : 32'd4);
    ev.pc_if = nxt;
    if (!bad && r[16:13] == 4'd0) begin
      ev.pc_if = '0;
      ev.pc_id = '0;
    end
    excused = !ev.last_op || ev.ptr || ev.dummy || ev.pc_set || m_prev_set;
    // Wrong PCs only where an exception covers them, unless forced
    if (bad || (excused && r[17])) begin
      ev.pc_if = ev.pc_if ^ (next_rand() | 32'h1);
    end
    nxt = ev.pc_id + (ev.is_cmpr ? 32'd2 : 32'd4);
    cur_fault.seq = m_cfg.pc_hardening && ev.last_op && !ev.ptr && (ev.pc_if != nxt) &&
                    !(ev.dummy || ev.pc_set || m_prev_set ||
                      (ev.pc_if == '0 && ev.pc_id == '0));
    m_prev_set = ev.pc_set;
    fetch_i = ev;
    step();
  endtask

  task automatic send_redir(input logic bad_tgt, input logic bad_dec);
    pc_hard_pkg::redir_ev_t ev;
    logic [31:0]            r;
    r = next_rand();
    ev.valid = 1'b1;
    case (r[1:0])
      2'd2:    ev.kind = pc_hard_pkg::pc_jump;
      2'd3:    ev.kind = pc_hard_pkg::pc_mret;
      default: ev.kind = pc_hard_pkg::pc_branch;
    endcase
    ev.tgt_a = next_rand();
    ev.tgt_b = bad_tgt ? (ev.tgt_a ^ (next_rand() | 32'h1)) : ev.tgt_a;
    ev.cmp_a = r[2];
    ev.cmp_b = bad_dec ? !r[2] : r[2];
    cur_fault.tgt = m_cfg.pc_hardening && (ev.tgt_a != ev.tgt_b);
    cur_fault.dec = m_cfg.pc_hardening && (ev.kind == pc_hard_pkg::pc_branch) &&
                    !m_cfg.dataindtiming && (ev.cmp_a != ev.cmp_b);
    redir_i = ev;
    step();
  endtask

  // Write with random bready stall; model effects land at the acceptance edge
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    int unsigned wait_n;
    int unsigned stall;
    axil_i.awvalid = 1'b1;
    axil_i.awaddr  = addr;
    axil_i.wvalid  = 1'b1;
    axil_i.wdata   = data;
    axil_i.wstrb   = 4'hf;
    if (addr == pc_hard_pkg::reg_ctrl) m_cfg_nxt = pc_hard_pkg::hard_cfg_t'(data[1:0]);
    if (addr == pc_hard_pkg::reg_status) m_clr = pc_hard_pkg::fault_t'(data[2:0]);
    @(negedge clk_i);
    if (!axil_o.awready || !axil_o.wready) stop_on_error("Write was not accepted");
    step();
    axil_i.awvalid = 1'b0;
    axil_i.wvalid  = 1'b0;
    wait_n = 0;
    while (!axil_o.bvalid) begin
      if (wait_n == 8) stop_on_error("No write response arrived");
      wait_n++;
      step();
    end
    stall = next_rand() % 32'd4;
    repeat (stall) begin
      step();
      if (!axil_o.bvalid) stop_on_error("Write response dropped while bready was low");
    end
    check_resp("bresp", axil_o.bresp, exp_resp);
    axil_i.bready = 1'b1;
    step();
    axil_i.bready = 1'b0;
  endtask

  // Read with random rready stall; data must stay put while stalled
  task automatic axil_read(input logic [3:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
    int unsigned wait_n;
    int unsigned stall;
    logic [31:0] first;
    axil_i.arvalid = 1'b1;
    axil_i.araddr  = addr;
    @(negedge clk_i);
    if (!axil_o.arready) stop_on_error("Read was not accepted");
    step();
    axil_i.arvalid = 1'b0;
    wait_n = 0;
    while (!axil_o.rvalid) begin
      if (wait_n == 8) stop_on_error("No read response arrived");
      wait_n++;
      step();
    end
    first = axil_o.rdata;
    stall = next_rand() % 32'd4;
    repeat (stall) begin
      step();
      if (!axil_o.rvalid) stop_on_error("Read response dropped while rready was low");
      check_data(axil_o.rdata, first);
    end
    check_resp("rresp", axil_o.rresp, exp_resp);
    check_data(axil_o.rdata, exp_data);
    axil_i.rready = 1'b1;
    step();
    axil_i.rready = 1'b0;
  endtask

  initial begin
    seed         = 32'he4f2_fbd3;
    reset_i      = 1'b1;
    fetch_i      = '0;
    redir_i      = '0;
    redir_i.kind = pc_hard_pkg::pc_branch;
    axil_i       = '0;
    m_cfg        = 2'b01;
    m_cfg_nxt    = 2'b01;
    m_status     = '0;
    m_clr        = '0;
    cur_fault    = '0;
    m_count      = '0;
    m_prev_set   = 1'b0;
    alert_q.push_back(pc_hard_pkg::fault_t'(3'b000));
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Sequential fetch, every mismatch covered by an exception
    repeat (n_seq) send_fetch(1'b0);
    flush();
    // Sequential faults back to back
    repeat (n_flt) send_fetch(1'b1);
    flush();
    axil_read(pc_hard_pkg::reg_status, {29'd0, m_status}, pc_hard_pkg::resp_okay);
    axil_read(pc_hard_pkg::reg_count, {16'd0, m_count}, pc_hard_pkg::resp_okay);

    // Redirect faults, decision check on and then off
    for (int dit = 0; dit < 2; dit++) begin
      axil_write(pc_hard_pkg::reg_ctrl, {30'd0, dit[0], 1'b1}, pc_hard_pkg::resp_okay);
      repeat (n_redir) send_redir(next_rand() % 32'd4 == 0, next_rand() % 32'd3 == 0);
      flush();
      axil_read(pc_hard_pkg::reg_status, {29'd0, m_status}, pc_hard_pkg::resp_okay);
    end

    // Hardening off, corrupt events must leave no trace
    axil_write(pc_hard_pkg::reg_ctrl, 32'h0, pc_hard_pkg::resp_okay);
    saved_status = m_status;
    saved_count  = m_count;
    repeat (n_off) send_fetch(1'b1);
    repeat (n_off) send_redir(1'b1, 1'b1);
    flush();
    check_status(i_dut.status, saved_status);
    check_count(i_dut.count, saved_count);

    // Register port
    axil_write(pc_hard_pkg::reg_ctrl, 32'h3, pc_hard_pkg::resp_okay);
    axil_read(pc_hard_pkg::reg_ctrl, 32'h3, pc_hard_pkg::resp_okay);
    axil_write(pc_hard_pkg::reg_ctrl, 32'h1, pc_hard_pkg::resp_okay);
    axil_read(pc_hard_pkg::reg_ctrl, 32'h1, pc_hard_pkg::resp_okay);
    repeat (4) send_fetch(1'b1);
    repeat (8) send_redir(1'b1, 1'b1);
    flush();
    axil_read(pc_hard_pkg::reg_status, {29'd0, m_status}, pc_hard_pkg::resp_okay);
    // Clear only the target bit, the others stay
    axil_write(pc_hard_pkg::reg_status, 32'h2, pc_hard_pkg::resp_okay);
    axil_read(pc_hard_pkg::reg_status, {29'd0, m_status}, pc_hard_pkg::resp_okay);
    axil_write(pc_hard_pkg::reg_count, 32'hffff_ffff, pc_hard_pkg::resp_okay);
    axil_read(pc_hard_pkg::reg_count, {16'd0, m_count}, pc_hard_pkg::resp_okay);
    axil_read(4'hc, 32'h0, pc_hard_pkg::resp_slverr);
    axil_write(4'hc, 32'h7, pc_hard_pkg::resp_slverr);
    axil_write(pc_hard_pkg::reg_status, 32'h7, pc_hard_pkg::resp_okay);
    axil_read(pc_hard_pkg::reg_status, 32'h0, pc_hard_pkg::resp_okay);

    // Counter saturation
    repeat (sat_run) send_redir(1'b1, 1'b0);
    flush();
    check_count(i_dut.count, {pc_hard_pkg::cnt_w{1'b1}});
    axil_read(pc_hard_pkg::reg_count, 32'h0000_ffff, pc_hard_pkg::resp_okay);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- pc_hard_top.f
source/pc_hard_pkg.sv
source/pc_seq_check.sv
source/pc_target_check.sv
source/pc_alert_ctrl.sv
source/pc_hard_csr.sv
source/pc_hard_top.sv
tb/pc_hard_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the PC-hardening monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -Wno-fatal \
  -f pc_hard_top.f \
  --top-module pc_hard_tb \
  -o Vpc_hard_tb

# The log decides the result, so a fatal exit must not end the script here
./obj_dir/Vpc_hard_tb 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  exit 1
fi
exit 0
